// File: csr_pkg.sv
package csr_pkg;

  typedef logic [11:0] csr_addr_t;  // csr number
  typedef logic [31:0] csr_data_t;  // one data word
  typedef logic [63:0] cnt_t;       // full counter value
  typedef logic [5:0]  cause_t;     // bit 5 irq flag, 4:0 code
  typedef logic [1:0]  csr_op_t;

  // csr operations
  localparam csr_op_t CSR_OP_READ  = 2'd0;
  localparam csr_op_t CSR_OP_WRITE = 2'd1;
  localparam csr_op_t CSR_OP_SET   = 2'd2;
  localparam csr_op_t CSR_OP_CLEAR = 2'd3;

  // register addressed this cycle
  typedef enum logic [3:0] {
    SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MEPC, SEL_MCAUSE,
    SEL_MCOUNTINHIBIT, SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH
  } csr_sel_e;

  ////////////////////
  // addresses
  ////////////////////
  localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
  localparam csr_addr_t ADDR_MISA          = 12'h301;
  localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t ADDR_MEPC          = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
  localparam csr_addr_t ADDR_MCYCLE        = 12'hB00;
  localparam csr_addr_t ADDR_MINSTRET      = 12'hB02;
  localparam csr_addr_t ADDR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t ADDR_MINSTRETH     = 12'hB82;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;   // mpp is 12:11, always M-mode

  // mxl=1 (rv32), C, I and M extensions
  localparam logic [1:0] MISA_MXL   = 2'd1;
  localparam csr_data_t  MISA_VALUE = {MISA_MXL, 30'd0} | (32'd1 << 12) | (32'd1 << 8)
                                      | (32'd1 << 2);

  localparam int CNT_CYCLE_BIT   = 0;   // only implemented mcountinhibit bits
  localparam int CNT_INSTRET_BIT = 2;

endpackage

// File: csr_wr_if.sv
`timescale 1ns/1ps

interface csr_wr_if import csr_pkg::*; ();

  csr_sel_e  sel;    // register addressed this cycle
  logic      we;     // one-cycle commit strobe, legality already checked
  csr_data_t wdata;  // data after write/set/clear

  modport decode (output sel, output we);

  // result needs sel for the read mux
  modport result (input sel, output wdata);

  modport regs (input sel, input we, input wdata);

endinterface

// File: csr_rd_if.sv
`timescale 1ns/1ps

interface csr_rd_if import csr_pkg::*; ();

  // trap state
  logic      mie;
  logic      mpie;
  csr_data_t mepc;
  cause_t    mcause;

  // counter state
  csr_data_t mcountinhibit;  // unimplemented bits read zero
  cnt_t      mcycle;
  cnt_t      minstret;

  modport trap_regs (output mie, output mpie, output mepc, output mcause);

  modport counters (output mcountinhibit, output mcycle, output minstret);

  modport result (input mie, input mpie, input mepc, input mcause,
                  input mcountinhibit, input mcycle, input minstret);

endinterface

// File: csr_decode.sv
`timescale 1ns/1ps

module csr_decode import csr_pkg::*; (
  input  csr_addr_t csr_addr_i,
  input  csr_op_t   csr_op_i,
  input  logic      csr_access_i,
  input  logic      is_decoding_i,
  output logic      illegal_o,
  csr_wr_if.decode  wr
);

  csr_sel_e sel;
  logic     wreq;      // op modifies the register
  logic     ro_space;  // top two address bits 11
  logic     illegal;

  ////////////////////
  // address map
  ////////////////////
  always_comb begin
    unique case (csr_addr_i)
      ADDR_MSTATUS:       sel = SEL_MSTATUS;
      ADDR_MISA:          sel = SEL_MISA;
      ADDR_MEPC:          sel = SEL_MEPC;
      ADDR_MCAUSE:        sel = SEL_MCAUSE;
      ADDR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
      ADDR_MCYCLE:        sel = SEL_MCYCLE;
      ADDR_MCYCLEH:       sel = SEL_MCYCLEH;
      ADDR_MINSTRET:      sel = SEL_MINSTRET;
      ADDR_MINSTRETH:     sel = SEL_MINSTRETH;
      default:            sel = SEL_NONE;  // unknown csr
    endcase
  end

  assign wreq     = (csr_op_i != CSR_OP_READ);
  assign ro_space = (csr_addr_i[11:10] == 2'b11);

  // only flagged for a real access
  assign illegal = csr_access_i && ((sel == SEL_NONE) || (ro_space && wreq));

  // single place where a write is allowed
  // is_decoding keeps it to one cycle per instruction
  assign wr.we  = csr_access_i && is_decoding_i && wreq && !illegal;
  assign wr.sel = sel;

  assign illegal_o = illegal;

endmodule

// File: csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs import csr_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         csr_save_cause_i,
  input  logic         csr_save_if_i,
  input  logic         csr_restore_mret_i,
  input  cause_t       csr_cause_i,
  input  csr_data_t    pc_if_i,
  input  csr_data_t    pc_id_i,
  csr_wr_if.regs       wr,
  csr_rd_if.trap_regs  rd
);

  logic      mie_q, mie_d;
  logic      mpie_q, mpie_d;
  csr_data_t mepc_q, mepc_d;
  cause_t    mcause_q, mcause_d;
  csr_data_t exception_pc;

  // pc of the trapping instr, id stage unless fetch faulted
  assign exception_pc = csr_save_if_i ? pc_if_i : pc_id_i;

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // lowest priority, plain csr writes
    if (wr.we) begin
      unique case (wr.sel)
        SEL_MSTATUS: begin
          mie_d  = wr.wdata[MSTATUS_MIE_BIT];
          mpie_d = wr.wdata[MSTATUS_MPIE_BIT];  // mpp not stored
        end
        SEL_MEPC:   mepc_d   = wr.wdata;
        SEL_MCAUSE: mcause_d = {wr.wdata[31], wr.wdata[4:0]};  // irq flag + code
        default: ;  // not ours
      endcase
    end

    // trap entry
    if (csr_save_cause_i) begin
      mepc_d   = exception_pc;
      mcause_d = csr_cause_i;
      mpie_d   = mie_q;  // stack the enable
      mie_d    = 1'b0;
    end

    // mret wins over everything
    if (csr_restore_mret_i) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  assign rd.mie    = mie_q;
  assign rd.mpie   = mpie_q;
  assign rd.mepc   = mepc_q;
  assign rd.mcause = mcause_q;

endmodule

// File: csr_counters.sv
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        insn_ret_i,  // one instr retired this cycle
  csr_wr_if.regs      wr,
  csr_rd_if.counters  rd
);

  cnt_t      mcycle_q, minstret_q;
  logic      inh_cycle_q, inh_instret_q;  // stored mcountinhibit bits
  logic      inc_cycle, inc_instret;
  logic      we_inhibit;
  csr_data_t inhibit_word;

  // one step of a counter, half-word write overrides the increment
  function automatic cnt_t cnt_next(input cnt_t q, input logic inc, input logic we_lo,
                                    input logic we_hi, input csr_data_t wdata);
    cnt_t d;
    d = inc ? q + 64'd1 : q;
    if (we_lo) begin
      d[31:0] = wdata;
    end else if (we_hi) begin
      d[63:32] = wdata;
    end
    return d;
  endfunction

  assign inc_cycle   = !inh_cycle_q;                // always counting unless inhibited
  assign inc_instret = insn_ret_i && !inh_instret_q;
  assign we_inhibit  = wr.we && (wr.sel == SEL_MCOUNTINHIBIT);

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcycle_q      <= '0;
      minstret_q    <= '0;
      inh_cycle_q   <= 1'b0;
      inh_instret_q <= 1'b0;
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, inc_cycle, wr.we && (wr.sel == SEL_MCYCLE),
                             wr.we && (wr.sel == SEL_MCYCLEH), wr.wdata);
      minstret_q <= cnt_next(minstret_q, inc_instret, wr.we && (wr.sel == SEL_MINSTRET),
                             wr.we && (wr.sel == SEL_MINSTRETH), wr.wdata);
      if (we_inhibit) begin
        inh_cycle_q   <= wr.wdata[CNT_CYCLE_BIT];
        inh_instret_q <= wr.wdata[CNT_INSTRET_BIT];
      end
    end
  end

  // rebuild the full word, rest reads zero
  always_comb begin
    inhibit_word                  = '0;
    inhibit_word[CNT_CYCLE_BIT]   = inh_cycle_q;
    inhibit_word[CNT_INSTRET_BIT] = inh_instret_q;
  end

  assign rd.mcountinhibit = inhibit_word;
  assign rd.mcycle        = mcycle_q;
  assign rd.minstret      = minstret_q;

endmodule

// File: csr_result.sv
`timescale 1ns/1ps

module csr_result import csr_pkg::*; (
  input  csr_op_t     csr_op_i,
  input  csr_data_t   csr_wdata_i,
  output csr_data_t   csr_rdata_o,  // read word, zero latency
  csr_wr_if.result    wr,
  csr_rd_if.result    rd
);

  csr_data_t rdata;

  ////////////////////
  // read mux
  ////////////////////
  always_comb begin
    rdata = '0;  // SEL_NONE reads zero
    unique case (wr.sel)
      SEL_MSTATUS: begin
        rdata[MSTATUS_MPP_LO +: 2] = 2'b11;  // machine mode only
        rdata[MSTATUS_MPIE_BIT]    = rd.mpie;
        rdata[MSTATUS_MIE_BIT]     = rd.mie;
      end
      SEL_MISA:          rdata = MISA_VALUE;
      SEL_MEPC:          rdata = rd.mepc;
      SEL_MCAUSE:        rdata = {rd.mcause[5], 26'd0, rd.mcause[4:0]};
      SEL_MCOUNTINHIBIT: rdata = rd.mcountinhibit;
      SEL_MCYCLE:        rdata = rd.mcycle[31:0];
      SEL_MCYCLEH:       rdata = rd.mcycle[63:32];
      SEL_MINSTRET:      rdata = rd.minstret[31:0];
      SEL_MINSTRETH:     rdata = rd.minstret[63:32];
      default: ;
    endcase
  end

  // write data from the op, read op leaves wdata unused by the regs
  always_comb begin
    unique case (csr_op_i)
      CSR_OP_SET:   wr.wdata = csr_wdata_i | rdata;
      CSR_OP_CLEAR: wr.wdata = rdata & ~csr_wdata_i;
      default:      wr.wdata = csr_wdata_i;  // write and read
    endcase
  end

  assign csr_rdata_o = rdata;

endmodule

// File: csr_unit.sv
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // csr access from the id stage
  input  logic      csr_access_i,
  input  csr_addr_t csr_addr_i,
  input  csr_data_t csr_wdata_i,
  input  csr_op_t   csr_op_i,
  input  logic      is_decoding_i,   // controller in decode
  // trap control
  input  logic      csr_save_cause_i,
  input  logic      csr_save_if_i,
  input  logic      csr_save_id_i,   // id pc is the default choice
  input  logic      csr_restore_mret_i,
  input  cause_t    csr_cause_i,
  input  csr_data_t pc_if_i,
  input  csr_data_t pc_id_i,
  input  logic      insn_ret_i,
  output csr_data_t csr_rdata_o,
  output logic      illegal_csr_insn_o,
  output logic      m_irq_enable_o,
  output csr_data_t mepc_o
);

  csr_wr_if wr_bus ();  // decode/result -> register modules
  csr_rd_if rd_bus ();  // register state -> read mux

  csr_decode decode_i (
    .csr_addr_i    (csr_addr_i),
    .csr_op_i      (csr_op_i),
    .csr_access_i  (csr_access_i),
    .is_decoding_i (is_decoding_i),
    .illegal_o     (illegal_csr_insn_o),
    .wr            (wr_bus.decode)
  );

  csr_trap_regs trap_regs_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .wr                 (wr_bus.regs),
    .rd                 (rd_bus.trap_regs)
  );

  csr_counters counters_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .insn_ret_i (insn_ret_i),
    .wr         (wr_bus.regs),
    .rd         (rd_bus.counters)
  );

  csr_result result_i (
    .csr_op_i    (csr_op_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .wr          (wr_bus.result),
    .rd          (rd_bus.result)
  );

  // straight from the registers
  assign m_irq_enable_o = rd_bus.mie;
  assign mepc_o         = rd_bus.mepc;

endmodule

// File: csr_properties.sv
`timescale 1ns/1ps

module csr_properties import csr_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      csr_access_i,
  input csr_addr_t csr_addr_i,
  input logic      csr_save_cause_i,
  input logic      csr_save_if_i,
  input csr_data_t pc_if_i,
  input csr_data_t pc_id_i,
  input csr_data_t csr_rdata_o,
  input logic      illegal_csr_insn_o,
  input logic      m_irq_enable_o,
  input csr_data_t mepc_o
);

  int fail_count = 0;  // assertion failures so far

  // interrupts start disabled
  irq_off_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !m_irq_enable_o)
    else begin
      $error("m_irq_enable_o high in the first cycle after reset");
      fail_count++;
    end

  mpp_reads_m_mode: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (csr_addr_i == ADDR_MSTATUS) |-> (csr_rdata_o[12:11] == 2'b11))
    else begin
      $error("mstatus.mpp not read as 11");
      fail_count++;
    end

  // trap entry clears mie and latches the chosen pc
  trap_saves_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_save_cause_i |=> (!m_irq_enable_o
                          && mepc_o == $past(csr_save_if_i ? pc_if_i : pc_id_i)))
    else begin
      $error("trap entry did not clear mie or store the pc");
      fail_count++;
    end

  no_illegal_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !csr_access_i |-> !illegal_csr_insn_o)
    else begin
      $error("illegal_csr_insn_o high without an access");
      fail_count++;
    end

endmodule

// File: tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*; ();

  localparam int NUM_TXN     = 115;                   // driven cycles, roughly
  localparam int WATCHDOG_NS = (NUM_TXN + 20) * 100;  // 20 cycles of slack

  logic      clk_i = 1'b0;
  logic      rst_ni, csr_access_i, is_decoding_i, insn_ret_i;
  logic      csr_save_cause_i, csr_save_if_i, csr_save_id_i, csr_restore_mret_i;
  csr_addr_t csr_addr_i;
  csr_data_t csr_wdata_i, pc_if_i, pc_id_i, csr_rdata_o, mepc_o;
  csr_op_t   csr_op_i;
  cause_t    csr_cause_i;
  logic      illegal_csr_insn_o, m_irq_enable_o;

  // reference model of the trap state and inhibit bits
  logic        m_mie = 1'b0;
  logic        m_mpie = 1'b0;
  csr_data_t   m_mepc = '0;
  csr_data_t   m_mcause = '0;     // kept in read layout
  csr_data_t   m_inhibit = '0;
  logic [31:0] seed = 32'hbed597cb;

  csr_unit csr_unit_i (.*);
  bind csr_unit csr_properties props_i (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // mpp fixed at 11, mpie bit 7, mie bit 3
  function automatic csr_data_t mstatus_word();
    return {19'd0, 2'b11, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////
  // bus cycles
  ////////////////////
  task automatic csr_cycle(input csr_op_t op, input csr_addr_t addr, input csr_data_t wdata,
                           input csr_data_t exp_rdata, input logic exp_illegal);
    @(negedge clk_i);
    csr_access_i = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = wdata;
    #40;  // comb outputs settled, well before the edge
    check_val("csr_rdata_o", csr_rdata_o, exp_rdata);
    check_val("illegal_csr_insn_o", 32'(illegal_csr_insn_o), 32'(exp_illegal));
    check_val("m_irq_enable_o", 32'(m_irq_enable_o), 32'(m_mie));
    check_val("mepc_o", mepc_o, m_mepc);
  endtask

  task automatic sample_csr(input csr_addr_t addr, output csr_data_t val);
    @(negedge clk_i);
    csr_access_i = 1'b1;
    csr_op_i     = CSR_OP_READ;
    csr_addr_i   = addr;
    #40 val = csr_rdata_o;
  endtask

  task automatic read_trap_regs();
    csr_cycle(CSR_OP_READ, ADDR_MEPC, 32'd0, m_mepc, 1'b0);
    csr_cycle(CSR_OP_READ, ADDR_MCAUSE, 32'd0, m_mcause, 1'b0);
    csr_cycle(CSR_OP_READ, ADDR_MSTATUS, 32'd0, mstatus_word(), 1'b0);
  endtask

  task automatic trap_entry(input logic from_if);
    @(negedge clk_i);
    csr_access_i     = 1'b0;
    csr_save_cause_i = 1'b1;
    csr_save_if_i    = from_if;
    csr_save_id_i    = !from_if;
    pc_if_i          = lcg_next();
    pc_id_i          = lcg_next();
    csr_cause_i      = cause_t'(lcg_next());
    @(negedge clk_i);
    csr_save_cause_i = 1'b0;
    csr_save_if_i    = 1'b0;
    csr_save_id_i    = 1'b0;
    m_mepc   = from_if ? pc_if_i : pc_id_i;
    m_mcause = {csr_cause_i[5], 26'd0, csr_cause_i[4:0]};
    m_mpie   = m_mie;  // enable stacked
    m_mie    = 1'b0;
  endtask

  task automatic mret();
    @(negedge clk_i);
    csr_access_i       = 1'b0;
    csr_restore_mret_i = 1'b1;
    @(negedge clk_i);
    csr_restore_mret_i = 1'b0;
    m_mie  = m_mpie;
    m_mpie = 1'b1;
  endtask

  // any bound assertion failure ends the run
  always @(negedge clk_i) begin
    if (csr_unit_i.props_i.fail_count != 0) begin
      $display("Error at %0t: a bound assertion on csr_unit failed", $time);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t: the stimulus did not finish in time", $time);
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin : stimulus
    csr_data_t r, c0, c1, i0, i1;
    csr_op_t   op;
    int        pulses;
    rst_ni             = 1'b0;
    csr_access_i       = 1'b0;
    is_decoding_i      = 1'b1;  // core in decode by default
    insn_ret_i         = 1'b0;
    csr_save_cause_i   = 1'b0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_addr_i         = '0;
    csr_wdata_i        = '0;
    csr_op_i           = CSR_OP_READ;
    csr_cause_i        = '0;
    pc_if_i            = '0;
    pc_id_i            = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    ////////////////////
    // write and read back
    ////////////////////
    repeat (6) begin
      r = lcg_next();
      csr_cycle(CSR_OP_WRITE, ADDR_MEPC, r, m_mepc, 1'b0);  // old value still visible
      m_mepc = r;
      r = lcg_next();
      csr_cycle(CSR_OP_WRITE, ADDR_MCAUSE, r, m_mcause, 1'b0);
      m_mcause = {r[31], 26'd0, r[4:0]};
      csr_cycle(CSR_OP_READ, ADDR_MEPC, 32'd0, m_mepc, 1'b0);
      csr_cycle(CSR_OP_READ, ADDR_MCAUSE, 32'd0, m_mcause, 1'b0);
    end
    // rv32 with C, I, M
    csr_cycle(CSR_OP_WRITE, ADDR_MISA, lcg_next(), 32'h4000_1104, 1'b0);
    csr_cycle(CSR_OP_READ, ADDR_MISA, 32'd0, 32'h4000_1104, 1'b0);

    // stalled decode, the write must not land
    @(negedge clk_i) is_decoding_i = 1'b0;
    csr_cycle(CSR_OP_WRITE, ADDR_MEPC, lcg_next(), m_mepc, 1'b0);
    @(negedge clk_i);
    csr_access_i  = 1'b0;
    is_decoding_i = 1'b1;
    csr_cycle(CSR_OP_READ, ADDR_MEPC, 32'd0, m_mepc, 1'b0);

    // set/clear on mstatus
    repeat (8) begin
      r  = lcg_next();
      op = r[16] ? CSR_OP_SET : CSR_OP_CLEAR;
      csr_cycle(op, ADDR_MSTATUS, r, mstatus_word(), 1'b0);
      if (op == CSR_OP_SET) begin
        m_mie  = m_mie | r[3];
        m_mpie = m_mpie | r[7];
      end else begin
        m_mie  = m_mie & !r[3];
        m_mpie = m_mpie & !r[7];
      end
    end

    ////////////////////
    // traps
    ////////////////////
    csr_cycle(CSR_OP_WRITE, ADDR_MSTATUS, 32'h8, mstatus_word(), 1'b0);
    m_mie  = 1'b1;
    m_mpie = 1'b0;
    trap_entry(1'b1);  // fetch-side pc
    read_trap_regs();
    mret();
    read_trap_regs();
    csr_cycle(CSR_OP_CLEAR, ADDR_MSTATUS, 32'h8, mstatus_word(), 1'b0);
    m_mie = 1'b0;  // zero goes to mpie, mret sets it again
    trap_entry(1'b0);  // decode pc
    read_trap_regs();
    mret();
    read_trap_regs();

    // counters, mcycle runs every cycle
    sample_csr(ADDR_MCYCLE, c0);
    repeat (6) @(negedge clk_i);
    sample_csr(ADDR_MCYCLE, c1);
    check_val("mcycle delta", c1 - c0, 32'd7);
    pulses = 0;
    sample_csr(ADDR_MINSTRET, i0);
    repeat (12) begin
      @(negedge clk_i);
      r = lcg_next();
      insn_ret_i = r[20];
      pulses += int'(r[20]);
    end
    @(negedge clk_i) insn_ret_i = 1'b0;
    sample_csr(ADDR_MINSTRET, i1);
    check_val("minstret delta", i1 - i0, 32'(pulses));

    // both inhibited, only bits 0 and 2 stick
    r = lcg_next() | 32'h5;
    csr_cycle(CSR_OP_WRITE, ADDR_MCOUNTINHIBIT, r, m_inhibit, 1'b0);
    m_inhibit = r & 32'h5;
    csr_cycle(CSR_OP_READ, ADDR_MCOUNTINHIBIT, 32'd0, m_inhibit, 1'b0);
    sample_csr(ADDR_MCYCLE, c0);
    sample_csr(ADDR_MINSTRET, i0);
    repeat (5) @(negedge clk_i) insn_ret_i = 1'b1;
    @(negedge clk_i) insn_ret_i = 1'b0;
    sample_csr(ADDR_MCYCLE, c1);
    sample_csr(ADDR_MINSTRET, i1);
    check_val("mcycle frozen", c1, c0);
    check_val("minstret frozen", i1, i0);
    r = lcg_next();
    csr_cycle(CSR_OP_WRITE, ADDR_MCYCLEH, r, 32'd0, 1'b0);  // low half far from a wrap
    csr_cycle(CSR_OP_READ, ADDR_MCYCLEH, 32'd0, r, 1'b0);
    csr_cycle(CSR_OP_WRITE, ADDR_MCOUNTINHIBIT, 32'd0, m_inhibit, 1'b0);
    m_inhibit = '0;

    ////////////////////
    // illegal access
    ////////////////////
    r = lcg_next();
    csr_cycle(CSR_OP_WRITE, 12'h7C5, r, 32'd0, 1'b1);  // unmapped
    csr_cycle(CSR_OP_WRITE, 12'hC00, r, 32'd0, 1'b1);  // read-only space
    read_trap_regs();
    csr_cycle(CSR_OP_READ, ADDR_MCOUNTINHIBIT, 32'd0, m_inhibit, 1'b0);
    @(negedge clk_i);
    csr_access_i = 1'b0;
    csr_op_i     = CSR_OP_READ;
    csr_addr_i   = 12'hC00;
    #40 check_val("illegal_csr_insn_o", 32'(illegal_csr_insn_o), 32'd0);

    @(negedge clk_i);
    #10;
    if (csr_unit_i.props_i.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

// File: sim.f
csr_pkg.sv
csr_wr_if.sv
csr_rd_if.sv
csr_decode.sv
csr_trap_regs.sv
csr_counters.sv
csr_result.sv
csr_unit.sv
csr_properties.sv
tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_wr_if.sv
  - csr_rd_if.sv
  - csr_decode.sv
  - csr_trap_regs.sv
  - csr_counters.sv
  - csr_result.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_properties.sv
      - tb_csr_unit.sv
